// File: filelist.f
common/adc_view_pkg.sv
design/adc_readout.sv
design/channel_tracker.sv
design/frame_serializer.sv
design/video_timing.sv
hex_display/hex_text_render.sv
design/adc_view_top.sv
test/adc_model.sv
test/tb_adc_view_top.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_adc_view_top -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

echo "simulation finished without failures"
exit 0

// File: test/tb_adc_view_top.sv
`timescale 1ns/100ps

module tb_adc_view_top;
    import adc_view_pkg::*;

    localparam int conv_period     = 400;
    localparam int num_rows        = 8;
    localparam int num_probes      = 7;
    localparam int mode_ready      = 0;   // ready always high
    localparam int mode_random     = 1;   // random ready
    localparam int mode_hold       = 2;   // ready held low, frame left pending
    localparam int beat_timeout    = 1000;
    localparam int frame_cycles    = 624 * 295;
    localparam int h_to_line_start = 120;   // hsync start 504 to end of line 624
    localparam int lines_to_top    = 22;    // vsync line 273 to last line 294
    localparam int active_w        = 480;
    localparam int active_h        = 272;
    localparam logic [15:0] fg_color = 16'hFFE0;
    localparam logic [15:0] bg_color = 16'h0010;

    logic         clk_pixel;
    logic         rst;
    logic         adc_busy;
    logic         adc_first_data;
    logic [15:0]  adc_data;
    logic         out_ready;
    logic         adc_convst_n;
    logic         adc_cs_n;
    logic         adc_rd_n;
    logic         out_valid;
    logic [2:0]   out_chan;
    logic [15:0]  out_sample;
    logic [15:0]  out_peak;
    logic [15:0]  overrun_count;
    logic [15:0]  color;
    logic         hsync;
    logic         vsync;
    logic         blank;
    logic [127:0] frame_words;
    logic [2:0]   first_pos;

    // one frame per row, word 0 in the low 16 bits
    logic [127:0] tbl_words [num_rows] = '{
        128'h0008_0007_0006_0005_0004_0003_0002_0001,
        128'h4000_F000_0100_ABCD_1234_FFFF_7FFF_8000,
        128'h0000_FFFE_2222_0F0F_C000_0010_8001_7FFF,
        128'h8888_7777_6666_5555_4444_3333_2222_1111,
        128'hE001_0606_9000_0404_0303_0202_0101_7000,
        128'hFF00_00FF_F0F0_0F0F_AAAA_5555_CCCC_3333,
        128'h0123_4567_89AB_CDEF_FEDC_BA98_7654_3210,
        128'hDEAD_BEEF_CAFE_F00D_0BAD_1DEA_5EED_ACE0
    };
    int tbl_first [num_rows] = '{0, 0, 0, 3, 0, 0, 0, 0};   // row 3 realigns mid-frame
    int tbl_mode  [num_rows] = '{mode_ready, mode_random, mode_random, mode_ready,
                                 mode_hold, mode_hold, mode_hold, mode_random};
    int probe_x [num_probes] = '{1, 3, 8, 62, 95, 200, 500};
    int probe_y [num_probes] = '{1, 3, 4, 13, 10, 3, 2};

    logic [15:0] exp_latest  [num_channels];
    logic [15:0] exp_peak    [num_channels];
    logic [15:0] beat_sample [num_channels];
    logic [15:0] beat_peak   [num_channels];
    logic [15:0] held_sample [num_channels];
    logic [15:0] held_peak   [num_channels];
    int          exp_overrun;
    bit          held;

    adc_view_top #(
        .conv_period (conv_period)
    ) i_adc_view_top (
        .clk_pixel      (clk_pixel),
        .rst            (rst),
        .adc_busy       (adc_busy),
        .adc_first_data (adc_first_data),
        .adc_data       (adc_data),
        .out_ready      (out_ready),
        .adc_convst_n   (adc_convst_n),
        .adc_cs_n       (adc_cs_n),
        .adc_rd_n       (adc_rd_n),
        .out_valid      (out_valid),
        .out_chan       (out_chan),
        .out_sample     (out_sample),
        .out_peak       (out_peak),
        .overrun_count  (overrun_count),
        .color          (color),
        .hsync          (hsync),
        .vsync          (vsync),
        .blank          (blank)
    );

    adc_model i_adc_model (
        .clk_pixel      (clk_pixel),
        .rst            (rst),
        .adc_convst_n   (adc_convst_n),
        .adc_cs_n       (adc_cs_n),
        .adc_rd_n       (adc_rd_n),
        .frame_words    (frame_words),
        .first_pos      (first_pos),
        .adc_busy       (adc_busy),
        .adc_first_data (adc_first_data),
        .adc_data       (adc_data)
    );

    initial
    begin
        clk_pixel = 1'b0;
        forever #20 clk_pixel = ~clk_pixel;
    end

    task automatic stop_fail(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
            stop_fail($sformatf("ERR %s expected %h actual %h", name, expected, actual));
    endtask

    // signed magnitude, -32768 saturates
    function automatic logic [15:0] magnitude_of(input logic [15:0] w);
        if (w == 16'h8000)
            return 16'hFFFF;
        else if (w[15])
            return 16'h0000 - w;
        else
            return w;
    endfunction

    // 5x7 hex font, top row in the high byte
    function automatic logic [63:0] glyph_of(input logic [3:0] nib);
        case (nib)
            4'h0:    return 64'h0E11131519110E00;
            4'h1:    return 64'h040C040404040E00;
            4'h2:    return 64'h0E11010204081F00;
            4'h3:    return 64'h1F02040201110E00;
            4'h4:    return 64'h02060A121F020200;
            4'h5:    return 64'h1F101E0101110E00;
            4'h6:    return 64'h0608101E11110E00;
            4'h7:    return 64'h1F01020408080800;
            4'h8:    return 64'h0E11110E11110E00;
            4'h9:    return 64'h0E11110F01020C00;
            4'hA:    return 64'h0E11111F11111100;
            4'hB:    return 64'h1E11111E11111E00;
            4'hC:    return 64'h0E11101010110E00;
            4'hD:    return 64'h1C12111111121C00;
            4'hE:    return 64'h1F10101E10101F00;
            default: return 64'h1F10101E10101000;
        endcase
    endfunction

    function automatic logic [15:0] expected_color(input int x, input int y);
        int          cx;
        int          cy;
        int          digit;
        int          px;
        int          py;
        logic [15:0] w;
        logic [3:0]  nib;
        logic [63:0] g;
        logic [7:0]  row_bits;
        cx    = x / glyph_w;
        cy    = y / glyph_h;
        px    = x % glyph_w;
        py    = y % glyph_h;
        digit = cy * 16 + cx;
        if (cx >= 16 || digit >= 32 || px == glyph_w - 1)
            return bg_color;
        w        = exp_latest[digit / 4];
        nib      = w[15 - 4 * (digit % 4) -: 4];   // digit 0 is the top nibble
        g        = glyph_of(nib);
        row_bits = g[63 - 8 * py -: 8];
        return row_bits[4 - px] ? fg_color : bg_color;
    endfunction

    // tracker state after one frame of reads
    task automatic apply_row(input int r);
        int          chan;
        logic [15:0] w;
        chan = 0;
        for (int k = 0; k < num_channels; k++)
        begin
            if (k == tbl_first[r])
                chan = 0;   // first-data restarts the index
            w = tbl_words[r][k*16 +: 16];
            exp_latest[chan] = w;
            if (magnitude_of(w) > exp_peak[chan])
                exp_peak[chan] = magnitude_of(w);
            chan = (chan + 1) % num_channels;
        end
    endtask

    task automatic drive_row(input int r);
        @(posedge clk_pixel);
        #2;
        frame_words = tbl_words[r];
        first_pos   = 3'(tbl_first[r]);
        out_ready   = (tbl_mode[r] != mode_hold) && !held;
    endtask

    task automatic wait_convst();
        int n;
        n = 0;
        @(negedge clk_pixel);
        while (adc_convst_n)
        begin
            n++;
            if (n > conv_period + 8)
                stop_fail("no conversion start pulse from the DUT");
            @(negedge clk_pixel);
        end
    endtask

    task automatic collect_beats(input string tag, input bit rnd);
        int          b;
        int          n;
        bit          stalled;
        logic [2:0]  hold_chan;
        logic [15:0] hold_sample;
        logic [15:0] hold_peak;
        b       = 0;
        n       = 0;
        stalled = 0;
        while (b < num_channels)
        begin
            @(negedge clk_pixel);
            if (out_valid)
            begin
                if (stalled)
                begin
                    check_value({tag, " stalled chan"}, 32'(hold_chan), 32'(out_chan));
                    check_value({tag, " stalled sample"}, 32'(hold_sample), 32'(out_sample));
                    check_value({tag, " stalled peak"}, 32'(hold_peak), 32'(out_peak));
                end
                if (out_ready)
                begin
                    check_value($sformatf("%s beat %0d chan", tag, b), b, 32'(out_chan));
                    check_value($sformatf("%s beat %0d sample", tag, b),
                                32'(beat_sample[b]), 32'(out_sample));
                    check_value($sformatf("%s beat %0d peak", tag, b),
                                32'(beat_peak[b]), 32'(out_peak));
                    b++;
                    stalled = 0;
                end
                else
                begin
                    stalled     = 1;
                    hold_chan   = out_chan;
                    hold_sample = out_sample;
                    hold_peak   = out_peak;
                end
            end
            n++;
            if (n > beat_timeout)
                stop_fail({"stream beats did not arrive for ", tag});
            @(posedge clk_pixel);
            #2;
            out_ready = rnd ? 1'($urandom_range(0, 1)) : 1'b1;
        end
        @(negedge clk_pixel);
        check_value({tag, " valid after last beat"}, 32'd0, 32'(out_valid));   // no duplicate
        @(posedge clk_pixel);
        #2;
        out_ready = 1'b1;
    endtask

    // find cell (x, y) by counting syncs, which share the color pipeline delay
    task automatic probe_pixel(input int x, input int y);
        int n;
        int rises;
        bit prev;
        n    = 0;
        prev = vsync;
        @(negedge clk_pixel);
        while (!(vsync && !prev))
        begin
            prev = vsync;
            n++;
            if (n > 2 * frame_cycles)
                stop_fail("vsync never rose");
            @(negedge clk_pixel);
        end
        rises = 0;
        prev  = hsync;
        while (rises < lines_to_top + y)
        begin
            @(negedge clk_pixel);
            if (hsync && !prev)
                rises++;
            prev = hsync;
            n++;
            if (n > 2 * frame_cycles)
                stop_fail("hsync count did not reach the probed line");
        end
        repeat (h_to_line_start + x) @(negedge clk_pixel);
        check_value($sformatf("pixel %0d,%0d color", x, y), 32'(expected_color(x, y)),
                    32'(color));
        check_value($sformatf("pixel %0d,%0d blank", x, y),
                    32'((x >= active_w) || (y >= active_h)), 32'(blank));
    endtask

    initial
    begin
        void'($urandom(32'h220a));
        rst         = 1'b1;
        out_ready   = 1'b1;
        frame_words = '0;
        first_pos   = '0;
        exp_overrun = 0;
        held        = 0;
        for (int k = 0; k < num_channels; k++)
        begin
            exp_latest[k] = '0;
            exp_peak[k]   = '0;
        end
        repeat (16) @(posedge clk_pixel);
        #2;
        rst = 1'b0;

        for (int r = 0; r < num_rows; r++)
        begin
            drive_row(r);
            wait_convst();
            check_value($sformatf("row %0d overrun count", r), exp_overrun,
                        32'(overrun_count));
            apply_row(r);
            if (tbl_mode[r] == mode_hold)
            begin
                if (held)
                    exp_overrun++;   // this frame finds the stream busy
                else
                begin
                    held        = 1;
                    held_sample = exp_latest;
                    held_peak   = exp_peak;
                end
            end
            else
            begin
                if (held)
                begin
                    beat_sample = held_sample;
                    beat_peak   = held_peak;
                    collect_beats("held frame", tbl_mode[r] == mode_random);
                    held = 0;
                end
                beat_sample = exp_latest;
                beat_peak   = exp_peak;
                collect_beats($sformatf("row %0d", r), tbl_mode[r] == mode_random);
            end
        end

        for (int p = 0; p < num_probes; p++)
            probe_pixel(probe_x[p], probe_y[p]);

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: test/adc_model.sv
`timescale 1ns/100ps

module adc_model
#(
    parameter int busy_cycles = 20
)
(
    input  logic         clk_pixel,
    input  logic         rst,
    input  logic         adc_convst_n,
    input  logic         adc_cs_n,
    input  logic         adc_rd_n,
    input  logic [127:0] frame_words,   // word k at bits k*16 +: 16
    input  logic [2:0]   first_pos,     // read slot that carries first-data
    output logic         adc_busy,
    output logic         adc_first_data,
    output logic [15:0]  adc_data
);
    logic [127:0] words;
    logic [2:0]   first_q;
    logic [3:0]   idx;
    logic [7:0]   busy_cnt;
    logic         rd_q;

    always_ff @(posedge clk_pixel)
    begin
        if (rst)
        begin
            words    <= '0;
            first_q  <= '0;
            idx      <= '0;
            busy_cnt <= '0;
            rd_q     <= 1'b1;
        end
        else
        begin
            rd_q <= adc_rd_n;
            if (!adc_convst_n)
            begin
                // new conversion, the sample set is frozen here
                busy_cnt <= 8'(busy_cycles);
                idx      <= '0;
                words    <= frame_words;
                first_q  <= first_pos;
            end
            else
            begin
                if (busy_cnt != 8'd0)
                    busy_cnt <= busy_cnt - 8'd1;
                if (adc_rd_n && !rd_q)
                    idx <= idx + 4'd1;   // end of one read
            end
        end
    end

    assign adc_busy       = (busy_cnt != 8'd0);
    assign adc_first_data = (idx == {1'b0, first_q});
    assign adc_data       = adc_cs_n ? 16'h0000 : words[idx[2:0]*16 +: 16];

endmodule

// File: design/adc_view_top.sv
`timescale 1ns/100ps

module adc_view_top
#(
    parameter int conv_period = 1024
)
(
    input  logic        clk_pixel,
    input  logic        rst,
    input  logic        adc_busy,
    input  logic        adc_first_data,
    input  logic [15:0] adc_data,
    input  logic        out_ready,
    output logic        adc_convst_n,
    output logic        adc_cs_n,
    output logic        adc_rd_n,
    output logic        out_valid,
    output logic [2:0]  out_chan,
    output logic [15:0] out_sample,
    output logic [15:0] out_peak,
    output logic [15:0] overrun_count,
    output logic [15:0] color,
    output logic        hsync,
    output logic        vsync,
    output logic        blank
);
    import adc_view_pkg::*;

    logic                 sample_valid;
    logic [chan_bits-1:0] sample_chan;
    adc_word_u            sample_word;
    logic                 frame_done;
    adc_word_u            latest [num_channels];
    logic [15:0]          peak   [num_channels];
    logic [127:0]         disp_word;
    logic [9:0]           beam_x;
    logic [9:0]           beam_y;

    adc_readout #(
        .conv_period (conv_period)
    ) i_adc_readout (
        .clk_pixel      (clk_pixel),
        .rst            (rst),
        .adc_busy       (adc_busy),
        .adc_first_data (adc_first_data),
        .adc_data       (adc_data),
        .adc_convst_n   (adc_convst_n),
        .adc_cs_n       (adc_cs_n),
        .adc_rd_n       (adc_rd_n),
        .sample_valid   (sample_valid),
        .sample_chan    (sample_chan),
        .sample_word    (sample_word),
        .frame_done     (frame_done)
    );

    for (genvar k = 0; k < num_channels; k++)
    begin : g_tracker
        channel_tracker #(
            .chan_index (k)
        ) i_channel_tracker (
            .clk_pixel    (clk_pixel),
            .rst          (rst),
            .sample_valid (sample_valid),
            .sample_chan  (sample_chan),
            .sample_word  (sample_word),
            .latest       (latest[k]),
            .peak         (peak[k])
        );
    end

    frame_serializer i_frame_serializer (
        .clk_pixel     (clk_pixel),
        .rst           (rst),
        .frame_done    (frame_done),
        .latest        (latest),
        .peak          (peak),
        .out_ready     (out_ready),
        .out_valid     (out_valid),
        .out_chan      (out_chan),
        .out_sample    (out_sample),
        .out_peak      (out_peak),
        .disp_word     (disp_word),
        .overrun_count (overrun_count)
    );

    // 480x272 panel timing
    video_timing #(
        .res_x   (480),
        .h_front (24),
        .h_pulse (48),
        .h_back  (72),
        .res_y   (272),
        .v_front (1),
        .v_pulse (3),
        .v_back  (19)
    ) i_video_timing (
        .clk_pixel (clk_pixel),
        .rst       (rst),
        .beam_x    (beam_x),
        .beam_y    (beam_y),
        .hsync     (hsync),
        .vsync     (vsync),
        .blank     (blank)
    );

    hex_text_render #(
        .digits_per_row (16),
        .fg_color       (16'hFFE0),   // yellow on dark blue
        .bg_color       (16'h0010)
    ) i_hex_text_render (
        .clk_pixel (clk_pixel),
        .beam_x    (beam_x),
        .beam_y    (beam_y),
        .disp_word (disp_word),
        .color     (color)
    );

endmodule

// File: hex_display/hex_text_render.sv
`timescale 1ns/100ps

module hex_text_render
#(
    parameter int          digits_per_row = 16,
    parameter logic [15:0] fg_color       = 16'hFFFF,
    parameter logic [15:0] bg_color       = 16'h0000
)
(
    input  logic         clk_pixel,
    input  logic [9:0]   beam_x,
    input  logic [9:0]   beam_y,
    input  logic [127:0] disp_word,
    output logic [15:0]  color
);
    import adc_view_pkg::*;

    localparam int num_digits = num_channels * sample_bits / 4;
    localparam int digit_bits = $clog2(num_digits);

    logic [9:0]            cell_x;
    logic [9:0]            cell_y;
    logic [15:0]           digit_idx;
    logic                  in_text;
    logic [digit_bits-1:0] digit_sel;
    adc_word_u             word_sel;
    logic [3:0]            nibble_q;
    logic [2:0]            px_q;
    logic [2:0]            py_q;
    logic                  in_text_q;
    logic [63:0]           glyph;
    logic [7:0]            glyph_row;
    logic                  pixel_on;

    // which character cell the beam is in
    assign cell_x    = beam_x / 10'(glyph_w);
    assign cell_y    = beam_y / 10'(glyph_h);
    assign digit_idx = 16'(cell_y) * 16'(digits_per_row) + 16'(cell_x);
    assign in_text   = (cell_x < 10'(digits_per_row)) && (digit_idx < 16'(num_digits));
    assign digit_sel = in_text ? digit_idx[digit_bits-1:0] : '0;

    // four digits per channel word
    assign word_sel = disp_word[digit_sel[digit_bits-1:2] * sample_bits +: sample_bits];

    // stage 1, digit fetch
    always_ff @(posedge clk_pixel)
    begin
        nibble_q  <= word_sel.digits[digit_sel[1:0]];
        px_q      <= 3'(beam_x % 10'(glyph_w));
        py_q      <= 3'(beam_y % 10'(glyph_h));
        in_text_q <= in_text;
    end

    // 5x7 glyphs, one byte per row from the top, low five bits used
    always_comb
    begin
        case (nibble_q)
            4'h0:    glyph = 64'h0E_11_13_15_19_11_0E_00;
            4'h1:    glyph = 64'h04_0C_04_04_04_04_0E_00;
            4'h2:    glyph = 64'h0E_11_01_02_04_08_1F_00;
            4'h3:    glyph = 64'h1F_02_04_02_01_11_0E_00;
            4'h4:    glyph = 64'h02_06_0A_12_1F_02_02_00;
            4'h5:    glyph = 64'h1F_10_1E_01_01_11_0E_00;
            4'h6:    glyph = 64'h06_08_10_1E_11_11_0E_00;
            4'h7:    glyph = 64'h1F_01_02_04_08_08_08_00;
            4'h8:    glyph = 64'h0E_11_11_0E_11_11_0E_00;
            4'h9:    glyph = 64'h0E_11_11_0F_01_02_0C_00;
            4'hA:    glyph = 64'h0E_11_11_1F_11_11_11_00;
            4'hB:    glyph = 64'h1E_11_11_1E_11_11_1E_00;
            4'hC:    glyph = 64'h0E_11_10_10_10_11_0E_00;
            4'hD:    glyph = 64'h1C_12_11_11_11_12_1C_00;
            4'hE:    glyph = 64'h1F_10_10_1E_10_10_1F_00;
            default: glyph = 64'h1F_10_10_1E_10_10_10_00;   // F
        endcase
    end

    assign glyph_row = glyph[(glyph_h - 1 - py_q) * 8 +: 8];

    // rightmost column of the cell is spacing
    always_comb
    begin
        pixel_on = 1'b0;
        if (px_q < 3'(glyph_w - 1))
            pixel_on = glyph_row[3'(glyph_w - 2) - px_q];
    end

    // stage 2, font lookup
    always_ff @(posedge clk_pixel)
    begin
        color <= (in_text_q && pixel_on) ? fg_color : bg_color;
    end

endmodule

// File: design/video_timing.sv
`timescale 1ns/100ps

module video_timing
#(
    parameter int res_x   = 480,
    parameter int h_front = 24,
    parameter int h_pulse = 48,
    parameter int h_back  = 72,
    parameter int res_y   = 272,
    parameter int v_front = 1,
    parameter int v_pulse = 3,
    parameter int v_back  = 19
)
(
    input  logic       clk_pixel,
    input  logic       rst,
    output logic [9:0] beam_x,
    output logic [9:0] beam_y,
    output logic       hsync,
    output logic       vsync,
    output logic       blank
);
    localparam int h_total = res_x + h_front + h_pulse + h_back;
    localparam int v_total = res_y + v_front + v_pulse + v_back;

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic       hsync_raw;
    logic       vsync_raw;
    logic       blank_raw;
    logic [2:0] sync_d1;   // hsync, vsync, blank
    logic [2:0] sync_d2;

    always_ff @(posedge clk_pixel)
    begin
        if (rst)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (h_cnt == 10'(h_total - 1))
        begin
            h_cnt <= '0;
            if (v_cnt == 10'(v_total - 1))
                v_cnt <= '0;
            else
                v_cnt <= v_cnt + 1'b1;
        end
        else
        begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign hsync_raw = (h_cnt >= 10'(res_x + h_front)) && (h_cnt < 10'(res_x + h_front + h_pulse));
    assign vsync_raw = (v_cnt >= 10'(res_y + v_front)) && (v_cnt < 10'(res_y + v_front + v_pulse));
    assign blank_raw = (h_cnt >= 10'(res_x)) || (v_cnt >= 10'(res_y));

    // match the two-cycle renderer pipeline
    always_ff @(posedge clk_pixel)
    begin
        if (rst)
        begin
            sync_d1 <= 3'b001;
            sync_d2 <= 3'b001;
        end
        else
        begin
            sync_d1 <= {hsync_raw, vsync_raw, blank_raw};
            sync_d2 <= sync_d1;
        end
    end

    assign {hsync, vsync, blank} = sync_d2;
    assign beam_x = h_cnt;
    assign beam_y = v_cnt;

endmodule

// File: design/frame_serializer.sv
`timescale 1ns/100ps

module frame_serializer
(
    input  logic                    clk_pixel,
    input  logic                    rst,
    input  logic                    frame_done,
    input  adc_view_pkg::adc_word_u latest [adc_view_pkg::num_channels],
    input  logic [15:0]             peak [adc_view_pkg::num_channels],
    input  logic                    out_ready,
    output logic                    out_valid,
    output logic [2:0]              out_chan,
    output logic [15:0]             out_sample,
    output logic [15:0]             out_peak,
    output logic [127:0]            disp_word,
    output logic [15:0]             overrun_count
);
    import adc_view_pkg::*;

    logic [sample_bits-1:0] snap_sample [num_channels];
    logic [sample_bits-1:0] snap_peak   [num_channels];
    logic [chan_bits-1:0]   beat_idx;
    logic                   take;
    logic                   last_beat;

    assign take      = frame_done && !out_valid;   // idle, accept the frame
    assign last_beat = out_valid && out_ready && (beat_idx == chan_bits'(num_channels - 1));

    always_ff @(posedge clk_pixel)
    begin
        if (take)
        begin
            for (int k = 0; k < num_channels; k++)
            begin
                snap_sample[k] <= latest[k];
                snap_peak[k]   <= peak[k];
            end
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (rst)
        begin
            out_valid     <= 1'b0;
            beat_idx      <= '0;
            overrun_count <= '0;
            disp_word     <= '0;
        end
        else
        begin
            // the display follows every frame, sent or not
            if (frame_done)
            begin
                for (int k = 0; k < num_channels; k++)
                    disp_word[k*sample_bits +: sample_bits] <= latest[k];
            end
            if (frame_done && out_valid)
                overrun_count <= overrun_count + 1'b1;   // stream still busy, drop

            if (take)
            begin
                out_valid <= 1'b1;
                beat_idx  <= '0;
            end
            else if (last_beat)
            begin
                out_valid <= 1'b0;
                beat_idx  <= '0;
            end
            else if (out_valid && out_ready)
            begin
                beat_idx <= beat_idx + 1'b1;
            end
        end
    end

    assign out_chan   = beat_idx;
    assign out_sample = snap_sample[beat_idx];
    assign out_peak   = snap_peak[beat_idx];

    assert property (@(posedge clk_pixel) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_sample) && $stable(out_chan)))
        else $error("frame_serializer: beat changed while waiting for ready");

endmodule

// File: design/channel_tracker.sv
`timescale 1ns/100ps

module channel_tracker
#(
    parameter int chan_index = 0
)
(
    input  logic                    clk_pixel,
    input  logic                    rst,
    input  logic                    sample_valid,
    input  logic [2:0]              sample_chan,
    input  adc_view_pkg::adc_word_u sample_word,
    output adc_view_pkg::adc_word_u latest,
    output logic [15:0]             peak
);
    import adc_view_pkg::*;

    logic                   hit;
    logic [sample_bits-1:0] magnitude;

    assign hit = sample_valid && (sample_chan == chan_bits'(chan_index));

    // absolute value of the signed view
    always_comb
    begin
        if (sample_word.value == {1'b1, {(sample_bits-1){1'b0}}})
            magnitude = '1;   // 32768 does not fit, saturate
        else if (sample_word.value[sample_bits-1])
            magnitude = sample_bits'(-sample_word.value);
        else
            magnitude = sample_word.value;
    end

    always_ff @(posedge clk_pixel)
    begin
        if (hit)
            latest <= sample_word;
    end

    // peak hold since reset
    always_ff @(posedge clk_pixel)
    begin
        if (rst)
            peak <= '0;
        else if (hit && (magnitude > peak))
            peak <= magnitude;
    end

endmodule

// File: design/adc_readout.sv
`timescale 1ns/100ps

module adc_readout
#(
    parameter int conv_period = 1024
)
(
    input  logic                    clk_pixel,
    input  logic                    rst,
    input  logic                    adc_busy,
    input  logic                    adc_first_data,
    input  logic [15:0]             adc_data,
    output logic                    adc_convst_n,
    output logic                    adc_cs_n,
    output logic                    adc_rd_n,
    output logic                    sample_valid,
    output logic [2:0]              sample_chan,
    output adc_view_pkg::adc_word_u sample_word,
    output logic                    frame_done
);
    import adc_view_pkg::*;

    localparam int period_bits = $clog2(conv_period);
    localparam int win_bits    = $clog2(read_cycles);

    logic [period_bits-1:0] period_cnt;
    logic                   busy_q;
    logic                   busy_fall;
    logic                   reading;
    logic [win_bits-1:0]    win_cnt;    // position inside one read window
    logic [chan_bits-1:0]   win_num;    // windows done in this frame
    logic [chan_bits-1:0]   chan;       // channel the current window belongs to
    logic                   strobe;
    logic                   capture;

    // free-running conversion start
    always_ff @(posedge clk_pixel)
    begin
        if (rst)
        begin
            period_cnt   <= '0;
            adc_convst_n <= 1'b1;
        end
        else
        begin
            if (period_cnt == period_bits'(conv_period - 1))
                period_cnt <= '0;
            else
                period_cnt <= period_cnt + 1'b1;
            adc_convst_n <= (period_cnt != period_bits'(conv_period - 1));
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (rst)
            busy_q <= 1'b0;
        else
            busy_q <= adc_busy;
    end

    assign busy_fall = busy_q && !adc_busy;   // conversion finished
    assign capture   = reading && (win_cnt == win_bits'(capture_cycle));

    // read sequencer, eight windows after busy falls
    always_ff @(posedge clk_pixel)
    begin
        if (rst)
        begin
            reading      <= 1'b0;
            win_cnt      <= '0;
            win_num      <= '0;
            chan         <= '0;
            sample_valid <= 1'b0;
            frame_done   <= 1'b0;
        end
        else
        begin
            sample_valid <= capture;
            frame_done   <= 1'b0;
            if (busy_fall && !reading)
            begin
                reading <= 1'b1;
                win_cnt <= '0;
                win_num <= '0;
                chan    <= '0;
            end
            else if (reading)
            begin
                if (win_cnt == '0 && adc_first_data)
                    chan <= '0;   // realign on first data
                if (win_cnt == win_bits'(read_cycles - 1))
                begin
                    win_cnt <= '0;
                    chan    <= chan + 1'b1;
                    win_num <= win_num + 1'b1;
                    if (win_num == chan_bits'(num_channels - 1))
                    begin
                        reading    <= 1'b0;
                        frame_done <= 1'b1;
                    end
                end
                else
                begin
                    win_cnt <= win_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (capture)
        begin
            sample_chan <= chan;
            sample_word <= adc_data;
        end
    end

    // rd goes high right after the capture edge
    assign strobe   = reading && (win_cnt <= win_bits'(capture_cycle));
    assign adc_rd_n = !strobe;
    assign adc_cs_n = !strobe;

    // conv_period too short for eight windows would restart the ADC mid-read
    assert property (@(posedge clk_pixel) disable iff (rst)
        adc_busy |-> (adc_rd_n && adc_cs_n))
        else $error("adc_readout: read strobe active while busy is high");

endmodule

// File: common/adc_view_pkg.sv
package adc_view_pkg;

    // ADC geometry
    localparam int num_channels = 8;
    localparam int sample_bits  = 16;
    localparam int chan_bits    = 3;

    // per-channel read window, in clk_pixel cycles
    localparam int read_cycles   = 32;
    localparam int capture_cycle = 16;   // bus sampled here, rd still low

    // font cell
    localparam int glyph_w = 6;
    localparam int glyph_h = 8;

    // one ADC word, seen as a signed sample or as four hex digits
    typedef union packed {
        logic signed [sample_bits-1:0] value;
        logic [0:3][3:0]               digits;   // digits[0] is the top nibble
    } adc_word_u;

endpackage
